//--- vlog.f
cluster_periph_pkg.sv
perf_event_pipe.sv
perf_counter.sv
periph_regfile.sv
cluster_periph_top.sv
tb_cluster_periph.sv

//--- Makefile
# Verilator build and run of the cluster peripheral testbench.

VERILATOR ?= verilator
TOP       ?= tb_cluster_periph
FILELIST  ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --top $(TOP) -Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST LOG OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cluster_periph.sv
/*
 * Testbench of the cluster peripherals: random event traffic and register
 * accesses, checked against a cycle model of the counters and registers.
 */
module tb_cluster_periph;

  import cluster_periph_pkg::*;

  logic      clk_i;
  logic      rst_n_i;
  logic      reg_req_i;
  logic      reg_we_i;
  addr_t     reg_addr_i;
  data_t     reg_wdata_i;
  logic      reg_rvalid_o;
  data_t     reg_rdata_o;
  core_vec_t core_retired_i, icache_miss_i, icache_hit_i, icache_stall_i;
  logic      tcdm_accessed_i, tcdm_congested_i, dma_busy_i;
  core_vec_t cl_clint_o;
  logic      icache_prefetch_enable_o;

  integer seed = 32'h776e;
  int     mismatches = 0;
  int     timeouts = 0;
  data_t  wdata;

  // Model state is updated on the same clock edges as the DUT.
  cnt_t                       m_cnt [NumPerfCounters];
  perf_metric_e               m_metric [NumPerfCounters];
  hart_t                      m_hart [NumPerfCounters];
  logic [NumPerfCounters-1:0] m_en;
  core_vec_t                  m_clint;
  logic                       m_prefetch;
  // Events one stage behind the inputs.
  core_vec_t                  p_retired, p_miss, p_hit, p_stall;
  logic                       p_tcdm_acc, p_tcdm_cong, p_dma;

  cluster_periph_top cluster_periph_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic event_hit(perf_metric_e metric, hart_t hart);
    case (metric)
      METRIC_CYCLE:          return 1'b1;
      METRIC_RETIRED_INSTR:  return p_retired[hart];
      METRIC_TCDM_ACCESSED:  return p_tcdm_acc;
      METRIC_TCDM_CONGESTED: return p_tcdm_cong;
      METRIC_ICACHE_MISS:    return p_miss[hart];
      METRIC_ICACHE_HIT:     return p_hit[hart];
      METRIC_ICACHE_STALL:   return p_stall[hart];
      default:               return p_dma;
    endcase
  endfunction

  always @(posedge clk_i) begin
    logic wr;
    wr = reg_req_i && reg_we_i;
    if (!rst_n_i) begin
      for (int i = 0; i < NumPerfCounters; i++) begin
        m_cnt[i]    = '0;
        m_metric[i] = PerfMetricRst[i];
        m_hart[i]   = '0;
      end
      m_en       = '0;
      m_clint    = '0;
      m_prefetch = 1'b0;
    end else begin
      for (int i = 0; i < NumPerfCounters; i++) begin
        // A load in the same cycle drops that cycle's increment.
        if (wr && reg_addr_i == RegPerfCnt0 + addr_t'(8 * i)) begin
          m_cnt[i] = reg_wdata_i[CntW-1:0];
        end else if (m_en[i]) begin
          m_cnt[i] = m_cnt[i] + cnt_t'(event_hit(m_metric[i], m_hart[i]));
        end
        if (wr && reg_addr_i == RegPerfSel0 + addr_t'(8 * i)) begin
          m_metric[i] = perf_metric_e'(reg_wdata_i[SelMetricLsb +: MetricW]);
          m_hart[i]   = reg_wdata_i[SelHartLsb +: HartW];
        end
      end
      if (wr) begin
        case (reg_addr_i)
          RegPerfEn:     m_en = reg_wdata_i[NumPerfCounters-1:0];
          RegClintSet:   m_clint = m_clint | reg_wdata_i[NumCores-1:0];
          RegClintClear: m_clint = m_clint & ~reg_wdata_i[NumCores-1:0];
          RegPrefetchEn: m_prefetch = reg_wdata_i[0];
          default: ;
        endcase
      end
    end
    p_retired   = core_retired_i;
    p_miss      = icache_miss_i;
    p_hit       = icache_hit_i;
    p_stall     = icache_stall_i;
    p_tcdm_acc  = tcdm_accessed_i;
    p_tcdm_cong = tcdm_congested_i;
    p_dma       = dma_busy_i;
  end

  function automatic data_t expected_read(addr_t addr);
    data_t val;
    val = '0;
    if (addr == RegPerfEn) val = data_t'(m_en);
    if (addr == RegPrefetchEn) val = data_t'(m_prefetch);
    for (int i = 0; i < NumPerfCounters; i++) begin
      if (addr == RegPerfSel0 + addr_t'(8 * i)) begin
        val[SelMetricLsb +: MetricW] = m_metric[i];
        val[SelHartLsb +: HartW]     = m_hart[i];
      end
      if (addr == RegPerfCnt0 + addr_t'(8 * i)) val = data_t'(m_cnt[i]);
    end
    return val;
  endfunction

  task automatic check_value(string name, data_t exp, data_t got);
    assert (got === exp) else begin
      mismatches++;
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the write.
  task automatic write_reg(addr_t addr, data_t data);
    reg_req_i   = 1'b1;
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
  endtask

  task automatic read_check(addr_t addr);
    data_t exp;
    int    waited;
    exp        = expected_read(addr);
    reg_req_i  = 1'b1;
    reg_we_i   = 1'b0;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_req_i = 1'b0;
    waited    = 0;
    while (!reg_rvalid_o && waited < 10) begin
      @(negedge clk_i);
      waited++;
    end
    assert (reg_rvalid_o) else begin
      timeouts++;
      $display("Read of address %h got no response within 10 cycles", addr);
    end
    if (reg_rvalid_o) begin
      check_value($sformatf("reg_rdata_o[%h]", addr), exp, reg_rdata_o);
    end
  endtask

  task automatic read_counters();
    for (int i = 0; i < NumPerfCounters; i++) begin
      read_check(RegPerfSel0 + addr_t'(8 * i));
      read_check(RegPerfCnt0 + addr_t'(8 * i));
    end
  endtask

  task automatic set_events(bit active);
    core_retired_i   = active ? core_vec_t'($random(seed)) : '0;
    icache_miss_i    = active ? core_vec_t'($random(seed)) : '0;
    icache_hit_i     = active ? core_vec_t'($random(seed)) : '0;
    icache_stall_i   = active ? core_vec_t'($random(seed)) : '0;
    tcdm_accessed_i  = active ? 1'($random(seed)) : 1'b0;
    tcdm_congested_i = active ? 1'($random(seed)) : 1'b0;
    dma_busy_i       = active ? 1'($random(seed)) : 1'b0;
  endtask

  task automatic run_traffic(int cycles);
    for (int c = 0; c < cycles; c++) begin
      set_events(1'b1);
      @(negedge clk_i);
    end
    set_events(1'b0);
  endtask

  initial begin
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    set_events(1'b0);
    rst_n_i = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Reset state.
    read_check(RegPerfEn);
    read_check(RegPrefetchEn);
    read_counters();
    check_value("cl_clint_o", '0, data_t'(cl_clint_o));
    check_value("icache_prefetch_enable_o", '0, data_t'(icache_prefetch_enable_o));

    // Wake-up set and clear, prefetch enable.
    repeat (24) begin
      wdata = data_t'($random(seed));
      if ($random(seed) % 2 == 0) write_reg(RegClintSet, wdata);
      else write_reg(RegClintClear, wdata);
      check_value("cl_clint_o", data_t'(m_clint), data_t'(cl_clint_o));
    end
    read_check(RegClintSet);
    read_check(RegClintClear);
    repeat (4) begin
      write_reg(RegPrefetchEn, data_t'($random(seed)));
      check_value("icache_prefetch_enable_o", data_t'(m_prefetch),
                  data_t'(icache_prefetch_enable_o));
      read_check(RegPrefetchEn);
    end

    // Random metrics and harts under random traffic.
    for (int i = 0; i < NumPerfCounters; i++) begin
      write_reg(RegPerfSel0 + addr_t'(8 * i), {$random(seed), $random(seed)});
    end
    write_reg(RegPerfEn, 64'hf);
    run_traffic(200);
    write_reg(RegPerfEn, 64'h0);
    read_counters();

    // Disabled counters hold, loaded counters count on.
    write_reg(RegPerfEn, 64'h5);
    run_traffic(100);
    read_counters();
    write_reg(RegPerfCnt0 + 8'h08, {$random(seed), $random(seed)});
    write_reg(RegPerfCnt0 + 8'h18, {$random(seed), $random(seed)});
    write_reg(RegPerfEn, 64'hf);
    run_traffic(60);
    write_reg(RegPerfCnt0, {$random(seed), $random(seed)});
    run_traffic(60);
    write_reg(RegPerfEn, 64'h0);
    read_counters();

    // Every metric in turn.
    for (int m = 0; m < 8; m++) begin
      for (int i = 0; i < NumPerfCounters; i++) begin
        wdata = {$random(seed), $random(seed)};
        wdata[SelMetricLsb +: MetricW] = MetricW'(m);
        write_reg(RegPerfSel0 + addr_t'(8 * i), wdata);
      end
      write_reg(RegPerfEn, 64'hf);
      run_traffic(40);
      write_reg(RegPerfEn, 64'h0);
      read_counters();
    end
    read_check(8'h60);
    read_check(8'hf0);

    $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- cluster_periph_top.sv
/*
 * Cluster peripheral block: event pipeline, counter array and register file.
 */
module cluster_periph_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  cluster_periph_pkg::addr_t     reg_addr_i,
  input  cluster_periph_pkg::data_t     reg_wdata_i,
  output logic                          reg_rvalid_o,
  output cluster_periph_pkg::data_t     reg_rdata_o,

  input  cluster_periph_pkg::core_vec_t core_retired_i,
  input  cluster_periph_pkg::core_vec_t icache_miss_i,
  input  cluster_periph_pkg::core_vec_t icache_hit_i,
  input  cluster_periph_pkg::core_vec_t icache_stall_i,
  input  logic                          tcdm_accessed_i,
  input  logic                          tcdm_congested_i,
  input  logic                          dma_busy_i,

  output cluster_periph_pkg::core_vec_t cl_clint_o,
  output logic                          icache_prefetch_enable_o
);

  import cluster_periph_pkg::*;

  core_vec_t                  core_retired_q, icache_miss_q, icache_hit_q, icache_stall_q;
  logic                       tcdm_accessed_q, tcdm_congested_q, dma_busy_q;
  logic [NumPerfCounters-1:0] cnt_wr, sel_wr, cnt_en;
  data_t                      wdata;
  cnt_t                       cnt [NumPerfCounters];
  perf_metric_e               metric [NumPerfCounters];
  hart_t                      hart [NumPerfCounters];

  perf_event_pipe i_event_pipe (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .core_retired_i   (core_retired_i),
    .icache_miss_i    (icache_miss_i),
    .icache_hit_i     (icache_hit_i),
    .icache_stall_i   (icache_stall_i),
    .tcdm_accessed_i  (tcdm_accessed_i),
    .tcdm_congested_i (tcdm_congested_i),
    .dma_busy_i       (dma_busy_i),
    .core_retired_o   (core_retired_q),
    .icache_miss_o    (icache_miss_q),
    .icache_hit_o     (icache_hit_q),
    .icache_stall_o   (icache_stall_q),
    .tcdm_accessed_o  (tcdm_accessed_q),
    .tcdm_congested_o (tcdm_congested_q),
    .dma_busy_o       (dma_busy_q)
  );

  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_counter
    perf_counter #(
      .Index (i)
    ) i_counter (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .cnt_en_i         (cnt_en[i]),
      .cnt_wr_i         (cnt_wr[i]),
      .sel_wr_i         (sel_wr[i]),
      .wdata_i          (wdata),
      .core_retired_i   (core_retired_q),
      .icache_miss_i    (icache_miss_q),
      .icache_hit_i     (icache_hit_q),
      .icache_stall_i   (icache_stall_q),
      .tcdm_accessed_i  (tcdm_accessed_q),
      .tcdm_congested_i (tcdm_congested_q),
      .dma_busy_i       (dma_busy_q),
      .cnt_o            (cnt[i]),
      .metric_o         (metric[i]),
      .hart_o           (hart[i])
    );
  end

  periph_regfile i_regfile (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .reg_req_i                (reg_req_i),
    .reg_we_i                 (reg_we_i),
    .reg_addr_i               (reg_addr_i),
    .reg_wdata_i              (reg_wdata_i),
    .reg_rvalid_o             (reg_rvalid_o),
    .reg_rdata_o              (reg_rdata_o),
    .cnt_wr_o                 (cnt_wr),
    .sel_wr_o                 (sel_wr),
    .cnt_en_o                 (cnt_en),
    .wdata_o                  (wdata),
    .cnt_i                    (cnt),
    .metric_i                 (metric),
    .hart_i                   (hart),
    .cl_clint_o               (cl_clint_o),
    .icache_prefetch_enable_o (icache_prefetch_enable_o)
  );

endmodule

//--- periph_regfile.sv
/*
 * Register file of the cluster peripherals: bus decode, wake-up vector,
 * prefetch enable, counter enables, counter write strobes and read data.
 */
module periph_regfile (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic                                 reg_req_i,
  input  logic                                 reg_we_i,
  input  cluster_periph_pkg::addr_t            reg_addr_i,
  input  cluster_periph_pkg::data_t            reg_wdata_i,
  output logic                                 reg_rvalid_o,
  output cluster_periph_pkg::data_t            reg_rdata_o,

  output logic [cluster_periph_pkg::NumPerfCounters-1:0] cnt_wr_o,
  output logic [cluster_periph_pkg::NumPerfCounters-1:0] sel_wr_o,
  output logic [cluster_periph_pkg::NumPerfCounters-1:0] cnt_en_o,
  output cluster_periph_pkg::data_t            wdata_o,
  input  cluster_periph_pkg::cnt_t             cnt_i [cluster_periph_pkg::NumPerfCounters],
  input  cluster_periph_pkg::perf_metric_e     metric_i [cluster_periph_pkg::NumPerfCounters],
  input  cluster_periph_pkg::hart_t            hart_i [cluster_periph_pkg::NumPerfCounters],

  output cluster_periph_pkg::core_vec_t        cl_clint_o,
  output logic                                 icache_prefetch_enable_o
);

  import cluster_periph_pkg::*;

  logic                       wr_req;
  logic                       rd_req;
  logic [NumPerfCounters-1:0] perf_en_q;
  core_vec_t                  clint_q;
  logic                       prefetch_q;
  data_t                      rdata_d;
  data_t                      rdata_q;
  logic                       rvalid_q;

  assign wr_req = reg_req_i & reg_we_i;
  assign rd_req = reg_req_i & ~reg_we_i;

  // Counter strobes act in the request cycle.
  always_comb begin
    for (int i = 0; i < NumPerfCounters; i++) begin
      sel_wr_o[i] = wr_req && (reg_addr_i == RegPerfSel0 + addr_t'(8 * i));
      cnt_wr_o[i] = wr_req && (reg_addr_i == RegPerfCnt0 + addr_t'(8 * i));
    end
  end

  assign wdata_o  = reg_wdata_i;
  assign cnt_en_o = perf_en_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      perf_en_q  <= '0;
      clint_q    <= '0;
      prefetch_q <= 1'b0;
    end else if (wr_req) begin
      case (reg_addr_i)
        RegPerfEn:     perf_en_q  <= reg_wdata_i[NumPerfCounters-1:0];
        RegClintSet:   clint_q    <= clint_q | reg_wdata_i[NumCores-1:0];
        RegClintClear: clint_q    <= clint_q & ~reg_wdata_i[NumCores-1:0];
        RegPrefetchEn: prefetch_q <= reg_wdata_i[0];
        default: ;
      endcase
    end
  end

  assign cl_clint_o               = clint_q;
  assign icache_prefetch_enable_o = prefetch_q;

  // Read mux. Unmapped addresses and the wake-up set/clear registers read zero.
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      RegPerfEn:     rdata_d = data_t'(perf_en_q);
      RegPrefetchEn: rdata_d = data_t'(prefetch_q);
      default: ;
    endcase
    for (int i = 0; i < NumPerfCounters; i++) begin
      if (reg_addr_i == RegPerfSel0 + addr_t'(8 * i)) begin
        rdata_d[SelMetricLsb +: MetricW] = metric_i[i];
        rdata_d[SelHartLsb +: HartW]     = hart_i[i];
      end
      if (reg_addr_i == RegPerfCnt0 + addr_t'(8 * i)) begin
        rdata_d = data_t'(cnt_i[i]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rvalid_o = rvalid_q;
  assign reg_rdata_o  = rdata_q;

endmodule

//--- perf_counter.sv
/*
 * One 48-bit performance counter with its metric and hart selection,
 * enable, software load and event selection.
 */
module perf_counter #(
  parameter int unsigned Index = 0
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic                             cnt_en_i,
  input  logic                             cnt_wr_i,
  input  logic                             sel_wr_i,
  input  cluster_periph_pkg::data_t        wdata_i,

  input  cluster_periph_pkg::core_vec_t    core_retired_i,
  input  cluster_periph_pkg::core_vec_t    icache_miss_i,
  input  cluster_periph_pkg::core_vec_t    icache_hit_i,
  input  cluster_periph_pkg::core_vec_t    icache_stall_i,
  input  logic                             tcdm_accessed_i,
  input  logic                             tcdm_congested_i,
  input  logic                             dma_busy_i,

  output cluster_periph_pkg::cnt_t         cnt_o,
  output cluster_periph_pkg::perf_metric_e metric_o,
  output cluster_periph_pkg::hart_t        hart_o
);

  import cluster_periph_pkg::*;

  perf_metric_e metric_q;
  hart_t        hart_q;
  cnt_t         cnt_q;
  logic         inc;

  // Event of the selected metric; per-core metrics look at one hart.
  always_comb begin
    unique case (metric_q)
      METRIC_CYCLE:          inc = 1'b1;
      METRIC_RETIRED_INSTR:  inc = core_retired_i[hart_q];
      METRIC_TCDM_ACCESSED:  inc = tcdm_accessed_i;
      METRIC_TCDM_CONGESTED: inc = tcdm_congested_i;
      METRIC_ICACHE_MISS:    inc = icache_miss_i[hart_q];
      METRIC_ICACHE_HIT:     inc = icache_hit_i[hart_q];
      METRIC_ICACHE_STALL:   inc = icache_stall_i[hart_q];
      METRIC_DMA_BUSY:       inc = dma_busy_i;
      default:               inc = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      metric_q <= PerfMetricRst[Index];
      hart_q   <= '0;
    end else if (sel_wr_i) begin
      metric_q <= perf_metric_e'(wdata_i[SelMetricLsb +: MetricW]);
      hart_q   <= wdata_i[SelHartLsb +: HartW];
    end
  end

  // A software load wins over the increment of the same cycle.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_wr_i) begin
      cnt_q <= wdata_i[CntW-1:0];
    end else if (cnt_en_i) begin
      cnt_q <= cnt_q + cnt_t'(inc);
    end
  end

  assign cnt_o    = cnt_q;
  assign metric_o = metric_q;
  assign hart_o   = hart_q;

endmodule

//--- perf_event_pipe.sv
/*
 * Pipeline stage between the cluster event sources and the counter bank.
 */
module perf_event_pipe (
  input  logic                          clk_i,
  input  logic                          rst_n_i,

  input  cluster_periph_pkg::core_vec_t core_retired_i,
  input  cluster_periph_pkg::core_vec_t icache_miss_i,
  input  cluster_periph_pkg::core_vec_t icache_hit_i,
  input  cluster_periph_pkg::core_vec_t icache_stall_i,
  input  logic                          tcdm_accessed_i,
  input  logic                          tcdm_congested_i,
  input  logic                          dma_busy_i,

  output cluster_periph_pkg::core_vec_t core_retired_o,
  output cluster_periph_pkg::core_vec_t icache_miss_o,
  output cluster_periph_pkg::core_vec_t icache_hit_o,
  output cluster_periph_pkg::core_vec_t icache_stall_o,
  output logic                          tcdm_accessed_o,
  output logic                          tcdm_congested_o,
  output logic                          dma_busy_o
);

  import cluster_periph_pkg::*;

  core_vec_t core_retired_q, icache_miss_q, icache_hit_q, icache_stall_q;
  logic      tcdm_accessed_q, tcdm_congested_q, dma_busy_q;

  // All counters see the same event cycle.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      core_retired_q   <= '0;
      icache_miss_q    <= '0;
      icache_hit_q     <= '0;
      icache_stall_q   <= '0;
      tcdm_accessed_q  <= 1'b0;
      tcdm_congested_q <= 1'b0;
      dma_busy_q       <= 1'b0;
    end else begin
      core_retired_q   <= core_retired_i;
      icache_miss_q    <= icache_miss_i;
      icache_hit_q     <= icache_hit_i;
      icache_stall_q   <= icache_stall_i;
      tcdm_accessed_q  <= tcdm_accessed_i;
      tcdm_congested_q <= tcdm_congested_i;
      dma_busy_q       <= dma_busy_i;
    end
  end

  assign core_retired_o   = core_retired_q;
  assign icache_miss_o    = icache_miss_q;
  assign icache_hit_o     = icache_hit_q;
  assign icache_stall_o   = icache_stall_q;
  assign tcdm_accessed_o  = tcdm_accessed_q;
  assign tcdm_congested_o = tcdm_congested_q;
  assign dma_busy_o       = dma_busy_q;

endmodule

//--- cluster_periph_pkg.sv
/*
 * Shared widths, typedefs, the performance metric encoding, the reset
 * metric table and the register address map of the cluster peripherals.
 */
package cluster_periph_pkg;

  localparam int unsigned NumCores        = 4;
  localparam int unsigned NumPerfCounters = 4;
  localparam int unsigned HartW           = 2;
  localparam int unsigned CntW            = 48;
  localparam int unsigned DataW           = 64;
  localparam int unsigned AddrW           = 8;
  localparam int unsigned MetricW         = 3;

  typedef logic [DataW-1:0]    data_t;
  typedef logic [AddrW-1:0]    addr_t;
  typedef logic [CntW-1:0]     cnt_t;
  typedef logic [HartW-1:0]    hart_t;
  typedef logic [NumCores-1:0] core_vec_t;

  // Per-core metrics use the hart field of the selection register.
  typedef enum logic [MetricW-1:0] {
    METRIC_CYCLE          = 3'd0,
    METRIC_RETIRED_INSTR  = 3'd1,
    METRIC_TCDM_ACCESSED  = 3'd2,
    METRIC_TCDM_CONGESTED = 3'd3,
    METRIC_ICACHE_MISS    = 3'd4,
    METRIC_ICACHE_HIT     = 3'd5,
    METRIC_ICACHE_STALL   = 3'd6,
    METRIC_DMA_BUSY       = 3'd7
  } perf_metric_e;

  // Metric tracked by each counter right after reset.
  localparam perf_metric_e PerfMetricRst [NumPerfCounters] = '{
    METRIC_CYCLE,
    METRIC_RETIRED_INSTR,
    METRIC_TCDM_ACCESSED,
    METRIC_ICACHE_MISS
  };

  // Byte offsets with one 64-bit register every 8 bytes.
  localparam addr_t RegPerfEn     = 8'h00;
  localparam addr_t RegPerfSel0   = 8'h08;
  localparam addr_t RegPerfCnt0   = 8'h28;
  localparam addr_t RegClintSet   = 8'h48;
  localparam addr_t RegClintClear = 8'h50;
  localparam addr_t RegPrefetchEn = 8'h58;

  // Field positions inside a selection register.
  localparam int unsigned SelMetricLsb = 0;
  localparam int unsigned SelHartLsb   = 16;

endpackage
